// ==== Bender.yml ====
package:
  name: frontend

sources:
  # Package first, then leaf modules, then the top level
  - src/frontend_pkg.sv
  - src/fifo_fwft.sv
  - src/prefetch_buf.sv
  - src/fetch_seq.sv
  - src/frontend_top.sv

  - target: test
    files:
      - test/tb_frontend.sv

// ==== src/fetch_seq.sv ====
// Fetch sequencer with window requests, response kill, slot PCs and fault stall
`timescale 1ns/1ps

module fetch_seq (
   input  logic                                                    clk,
   input  logic                                                    rst,
   input  logic                                                    redirect,
   input  logic [frontend_pkg::pc_w-1:0]                           redirect_pc,
   input  logic                                                    iq_ready,
   output logic                                                    mem_req,
   output logic [frontend_pkg::pc_w-1:0]                           mem_addr,
   input  frontend_pkg::mem_rsp_t                                  mem_rsp,
   output frontend_pkg::iq_entry_t [frontend_pkg::fetch_width-1:0] iq_entry,
   output logic [frontend_pkg::p_fetch_width:0]                    iq_push_cnt,
   output logic [frontend_pkg::p_fetch_width-1:0]                  iq_push_offset
);

   import frontend_pkg::*;

   // Held low for the first cycle after reset
   logic                     run;
   logic [pc_w-1:0]          fetch_pc;
   // PC of the request in flight, unaligned part kept for the offset
   logic [pc_w-1:0]          req_pc;
   logic                     req_live;
   logic                     fault_stall;
   logic                     rsp_take;
   logic                     rsp_fault;
   logic [p_fetch_width-1:0] offset;

   assign offset = req_pc[p_fetch_width+1:2];

   // A redirect in the response cycle discards the window
   assign rsp_take = mem_rsp.valid & req_live & ~redirect;
   assign rsp_fault = rsp_take & mem_rsp.fault;

   // Window address is always aligned
   assign mem_addr = {fetch_pc[pc_w-1:p_fetch_width+2], {(p_fetch_width + 2){1'b0}}};

   // A faulting answer also blocks the request of the same cycle
   assign mem_req = run & iq_ready & ~fault_stall & ~rsp_fault & ~redirect;

   assign iq_push_cnt = rsp_take ? (p_fetch_width + 1)'(fetch_width) - {1'b0, offset} : '0;
   assign iq_push_offset = offset;

   // Slot PCs rebuilt from the requested window
   always_comb
   begin
      for (int s = 0; s < fetch_width; s++)
      begin
         iq_entry[s].ins = mem_rsp.data[s*insn_w +: insn_w];
         iq_entry[s].pc = {req_pc[pc_w-1:p_fetch_width+2], p_fetch_width'(s), 2'b00};
         iq_entry[s].exc = mem_rsp.fault;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_req)
      begin
         req_pc <= fetch_pc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         run <= 1'b0;
         fetch_pc <= reset_pc;
         req_live <= 1'b0;
         fault_stall <= 1'b0;
      end
      else
      begin
         run <= 1'b1;
         // Requests never coincide with a redirect, so one live bit suffices
         req_live <= mem_req;
         if (redirect)
         begin
            fetch_pc <= redirect_pc;
         end
         else if (mem_req)
         begin
            fetch_pc <= mem_addr + pc_w'(fetch_width * 4);
         end
         // Stall stays until software steers fetch elsewhere
         if (redirect)
         begin
            fault_stall <= 1'b0;
         end
         else if (rsp_fault)
         begin
            fault_stall <= 1'b1;
         end
      end
   end

endmodule

// ==== src/fifo_fwft.sv ====
// First-word-fall-through FIFO with flush and two-entry headroom ready
`timescale 1ns/1ps

module fifo_fwft #(
   parameter int dw = 32,
   parameter int depth_width = 2
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          flush,
   input  logic          push,
   input  logic [dw-1:0] din,
   input  logic          pop,
   output logic [dw-1:0] dout,
   output logic          valid,
   output logic          ready
);

   logic [dw-1:0]          mem [1 << depth_width];
   logic [depth_width-1:0] rd_ptr;
   logic [depth_width-1:0] wr_ptr;
   logic [depth_width:0]   count;
   logic                   do_push;
   logic                   do_pop;

   // Pop only a present entry
   assign do_pop = pop & valid;

   // Full bank still takes a push when the head leaves in the same cycle
   assign do_push = push & ((count < (1 << depth_width)) | do_pop);

   // Oldest entry always on the output
   assign dout = mem[rd_ptr];
   assign valid = (count != '0);

   // Room for one window in flight plus the next one
   assign ready = (count + 2 <= (1 << depth_width));

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + do_push - do_pop;
      end
   end

endmodule

// ==== src/frontend_pkg.sv ====
// Front end widths, reset PC, queue entry and memory answer structs
package frontend_pkg;

   // Fetch window of four aligned instructions
   localparam int p_fetch_width = 2;
   localparam int fetch_width = 1 << p_fetch_width;

   // Decode takes up to two entries per cycle
   localparam int p_issue_width = 1;
   localparam int issue_width = 1 << p_issue_width;

   // Entries per bank FIFO, log2
   localparam int p_bank_depth = 2;

   localparam int insn_w = 32;
   localparam int pc_w = 32;

   // Fetch starts here after reset
   localparam logic [pc_w-1:0] reset_pc = 32'h0000_1000;

   // One queued instruction
   typedef struct packed {
      logic [insn_w-1:0] ins;
      logic [pc_w-1:0]   pc;
      logic              exc;
   } iq_entry_t;

   // One memory answer, slot 0 in the low bits of data
   typedef struct packed {
      logic                           valid;
      logic                           fault;
      logic [fetch_width*insn_w-1:0]  data;
   } mem_rsp_t;

endpackage

// ==== src/frontend_top.sv ====
// Front end top with fetch sequencer and prefetch buffer
`timescale 1ns/1ps

module frontend_top (
   input  logic                                                    clk,
   input  logic                                                    rst,
   output logic                                                    mem_req,
   output logic [frontend_pkg::pc_w-1:0]                           mem_addr,
   input  frontend_pkg::mem_rsp_t                                  mem_rsp,
   input  logic                                                    redirect,
   input  logic [frontend_pkg::pc_w-1:0]                           redirect_pc,
   output frontend_pkg::iq_entry_t [frontend_pkg::issue_width-1:0] id_entry,
   output logic [frontend_pkg::issue_width-1:0]                    id_valid,
   input  logic [frontend_pkg::p_issue_width:0]                    id_pop_cnt
);

   import frontend_pkg::*;

   iq_entry_t [fetch_width-1:0] iq_entry;
   logic [p_fetch_width:0]      iq_push_cnt;
   logic [p_fetch_width-1:0]    iq_push_offset;
   logic                        iq_ready;

   fetch_seq u_fetch_seq (
      .clk            (clk),
      .rst            (rst),
      .redirect       (redirect),
      .redirect_pc    (redirect_pc),
      .iq_ready       (iq_ready),
      .mem_req        (mem_req),
      .mem_addr       (mem_addr),
      .mem_rsp        (mem_rsp),
      .iq_entry       (iq_entry),
      .iq_push_cnt    (iq_push_cnt),
      .iq_push_offset (iq_push_offset)
   );

   // Redirect empties the queue
   prefetch_buf u_prefetch_buf (
      .clk            (clk),
      .rst            (rst),
      .flush          (redirect),
      .iq_entry       (iq_entry),
      .iq_push_cnt    (iq_push_cnt),
      .iq_push_offset (iq_push_offset),
      .iq_ready       (iq_ready),
      .id_entry       (id_entry),
      .id_valid       (id_valid),
      .id_pop_cnt     (id_pop_cnt)
   );

endmodule

// ==== src/prefetch_buf.sv ====
// Banked prefetch buffer with rotated push and issue slots
`timescale 1ns/1ps

module prefetch_buf (
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic                                                   flush,
   input  frontend_pkg::iq_entry_t [frontend_pkg::fetch_width-1:0] iq_entry,
   input  logic [frontend_pkg::p_fetch_width:0]                   iq_push_cnt,
   input  logic [frontend_pkg::p_fetch_width-1:0]                 iq_push_offset,
   output logic                                                   iq_ready,
   output frontend_pkg::iq_entry_t [frontend_pkg::issue_width-1:0] id_entry,
   output logic [frontend_pkg::issue_width-1:0]                   id_valid,
   input  logic [frontend_pkg::p_issue_width:0]                   id_pop_cnt
);

   import frontend_pkg::*;

   // Bank of the oldest entry and bank of the next free slot
   logic [p_fetch_width-1:0] head_ff;
   logic [p_fetch_width-1:0] tail_ff;
   logic [p_fetch_width:0]   pop_cnt;
   logic [fetch_width-1:0]   bank_push;
   logic [fetch_width-1:0]   bank_pop;
   logic [fetch_width-1:0]   bank_valid;
   logic [fetch_width-1:0]   bank_ready;
   iq_entry_t                bank_din [fetch_width];
   iq_entry_t                bank_dout [fetch_width];

   // Pop count widened to the bank pointer range
   assign pop_cnt = (p_fetch_width + 1)'(id_pop_cnt);

   for (genvar i = 0; i < fetch_width; i++)
   begin : gen_bank
      logic [p_fetch_width-1:0] tail_dist;
      logic [p_fetch_width-1:0] head_dist;
      logic [p_fetch_width-1:0] slot;

      // Distance of this bank from both pointers, modulo the bank count
      assign tail_dist = p_fetch_width'(i) - tail_ff;
      assign head_dist = p_fetch_width'(i) - head_ff;

      // Leading slots below the offset are not part of the window
      assign slot = tail_dist + iq_push_offset;

      assign bank_push[i] = ({1'b0, tail_dist} < iq_push_cnt);
      assign bank_din[i] = iq_entry[slot];
      assign bank_pop[i] = ({1'b0, head_dist} < pop_cnt);

      fifo_fwft #(
         .dw          ($bits(iq_entry_t)),
         .depth_width (p_bank_depth)
      ) u_fifo (
         .clk   (clk),
         .rst   (rst),
         .flush (flush),
         .push  (bank_push[i]),
         .din   (bank_din[i]),
         .pop   (bank_pop[i]),
         .dout  (bank_dout[i]),
         .valid (bank_valid[i]),
         .ready (bank_ready[i])
      );
   end

   // Issue slot k reads the bank k steps after the head
   for (genvar k = 0; k < issue_width; k++)
   begin : gen_issue
      logic [p_fetch_width-1:0] bank_sel;

      assign bank_sel = head_ff + p_fetch_width'(k);
      assign id_entry[k] = bank_dout[bank_sel];
      assign id_valid[k] = bank_valid[bank_sel];
   end

   // Every bank must take one more window beyond the one in flight
   assign iq_ready = &bank_ready;

   // Pointers wrap modulo the bank count, a full window leaves tail in place
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         head_ff <= '0;
         tail_ff <= '0;
      end
      else
      begin
         head_ff <= head_ff + pop_cnt[p_fetch_width-1:0];
         tail_ff <= tail_ff + iq_push_cnt[p_fetch_width-1:0];
      end
   end

endmodule

// ==== tb.f ====
src/frontend_pkg.sv
src/fifo_fwft.sv
src/prefetch_buf.sv
src/fetch_seq.sv
src/frontend_top.sv
test/tb_frontend.sv

// ==== test/tb_frontend.sv ====
// Testbench for the front end with memory responder, random decode pops, redirects and PC model
`timescale 1ns/1ps

module tb_frontend;

   import frontend_pkg::*;

   localparam int stim_cycles = 4000;
   // Five times the stimulus length leaves room for reset and drain
   localparam int timeout_cycles = stim_cycles * 5;
   localparam logic [pc_w-1:0] mem_base = 32'h0000_1000;

   logic                        clk;
   logic                        rst;
   logic                        mem_req;
   logic [pc_w-1:0]             mem_addr;
   mem_rsp_t                    mem_rsp;
   logic                        redirect;
   logic [pc_w-1:0]             redirect_pc;
   iq_entry_t [issue_width-1:0] id_entry;
   logic [issue_width-1:0]      id_valid;
   logic [p_issue_width:0]      id_pop_cnt;

   // Reference model state
   logic [pc_w-1:0] exp_pc;
   logic            fault_done;
   logic [pc_w-1:0] fault_lo;
   logic [pc_w-1:0] fault_hi;

   // Request seen in the previous cycle and answered in this one
   logic            req_seen;
   logic [pc_w-1:0] req_addr;

   int unsigned     pause_left;
   int unsigned     pops_total;
   int unsigned     exc_total;
   int unsigned     redirect_total;
   int unsigned     cycle_cnt;

   frontend_top dut (
      .clk         (clk),
      .rst         (rst),
      .mem_req     (mem_req),
      .mem_addr    (mem_addr),
      .mem_rsp     (mem_rsp),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .id_entry    (id_entry),
      .id_valid    (id_valid),
      .id_pop_cnt  (id_pop_cnt)
   );

   always
   begin
      #10 clk = ~clk;
   end

   // Instruction word at a byte address is the address mixed and rotated left by 7
   function automatic logic [insn_w-1:0] insn_at(input logic [pc_w-1:0] addr);
      logic [insn_w-1:0] mixed;
      mixed = addr ^ 32'h5a5a_0000;
      return {mixed[insn_w-8:0], mixed[insn_w-1:insn_w-7]};
   endfunction

   // Window of this address lies in the current fault region
   function automatic logic window_faults(input logic [pc_w-1:0] addr);
      logic [pc_w-1:0] win;
      win = {addr[pc_w-1:4], 4'h0};
      return (win >= fault_lo) && (win < fault_hi);
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
      begin
         fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, actual, expected));
      end
   endtask

   // Answer the request of the previous cycle
   task automatic drive_memory();
      mem_rsp_t rsp;
      rsp = '0;
      if (req_seen)
      begin
         rsp.valid = 1'b1;
         rsp.fault = window_faults(req_addr);
         for (int s = 0; s < fetch_width; s++)
         begin
            rsp.data[s*insn_w +: insn_w] = insn_at(req_addr + pc_w'(s * 4));
         end
      end
      mem_rsp = rsp;
   endtask

   // Decode side picks a pop count and checks the popped entries
   task automatic pop_and_check();
      int unsigned avail;
      int unsigned n;
      iq_entry_t   ent;
      if (id_valid == 2'b10)
      begin
         fail_run("Second issue slot is valid while the first one is empty");
      end
      avail = id_valid[0] ? (id_valid[1] ? 2 : 1) : 0;
      // Nothing may follow the last slot of a faulting window
      if (fault_done)
      begin
         check_value("id_valid", id_valid, '0);
      end
      if (pause_left > 0)
      begin
         n = 0;
         pause_left--;
      end
      else
      begin
         n = $urandom % 3;
         if ($urandom % 100 == 0)
         begin
            pause_left = 8 + $urandom % 24;
         end
      end
      if (n > avail)
      begin
         n = avail;
      end
      for (int k = 0; k < int'(n); k++)
      begin
         ent = id_entry[k];
         check_value($sformatf("id_entry[%0d].pc", k), ent.pc, exp_pc);
         check_value($sformatf("id_entry[%0d].ins", k), ent.ins, insn_at(exp_pc));
         check_value($sformatf("id_entry[%0d].exc", k), ent.exc, window_faults(exp_pc));
         if (ent.exc)
         begin
            exc_total++;
            if (exp_pc[3:2] == 2'd3)
            begin
               fault_done = 1'b1;
            end
         end
         exp_pc = exp_pc + 4;
         pops_total++;
      end
      id_pop_cnt = (p_issue_width + 1)'(n);
   endtask

   // Random redirect that opens a new fault region
   task automatic maybe_redirect();
      int unsigned     chance;
      logic [pc_w-1:0] target;
      // More likely right behind a request so the window in flight gets killed
      chance = req_seen ? 20 : 48;
      if ($urandom % chance == 0)
      begin
         fault_lo = mem_base + pc_w'(($urandom % 256) * 16);
         fault_hi = fault_lo + pc_w'((2 + $urandom % 4) * 16);
         if ($urandom % 2 == 0)
         begin
            target = fault_lo - pc_w'(($urandom % 8) * 4);
         end
         else
         begin
            target = mem_base + pc_w'(($urandom % 1024) * 4);
         end
         redirect = 1'b1;
         redirect_pc = target;
         exp_pc = target;
         fault_done = 1'b0;
         redirect_total++;
      end
      else
      begin
         redirect = 1'b0;
         redirect_pc = '0;
      end
   endtask

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_cycles)
      begin
         fail_run("Timeout, the run went past its cycle limit");
      end
   end

   initial
   begin
      void'($urandom(32'hab65));
      clk = 1'b0;
      rst = 1'b1;
      redirect = 1'b0;
      redirect_pc = '0;
      mem_rsp = '0;
      id_pop_cnt = '0;
      exp_pc = reset_pc;
      fault_done = 1'b0;
      // Empty fault region until the first redirect
      fault_lo = '0;
      fault_hi = '0;
      req_seen = 1'b0;
      req_addr = '0;
      pause_left = 0;
      pops_total = 0;
      exc_total = 0;
      redirect_total = 0;
      cycle_cnt = 0;

      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("mem_req", mem_req, 0);
      check_value("id_valid", id_valid, 0);
      @(posedge clk);
      #2;
      rst = 1'b0;
      // First cycle out of reset stays quiet
      @(negedge clk);
      check_value("mem_req", mem_req, 0);
      check_value("id_valid", id_valid, 0);
      req_seen = mem_req;
      req_addr = mem_addr;

      for (int cyc = 0; cyc < stim_cycles; cyc++)
      begin
         @(posedge clk);
         #2;
         drive_memory();
         pop_and_check();
         maybe_redirect();
         @(negedge clk);
         req_seen = mem_req;
         req_addr = mem_addr;
         if (mem_req)
         begin
            check_value("mem_addr[3:0]", mem_addr[3:0], '0);
         end
      end

      if ((pops_total > 0) && (redirect_total > 0) && (exc_total > 0))
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
      begin
         fail_run("Run ended without pops, redirects or faulting entries to check");
      end
   end

endmodule
